// File: src/fpFmtPkg.sv
// fpFmtPkg: default floating-point format sizes shared by the divider back end and its testbench
`default_nettype none

package fpFmtPkg;

  // exponent field width of the packed result
  localparam int defaultNe = 5;

  // fraction field width, hidden bit not counted
  localparam int defaultNf = 10;

  // quotient fraction bits from the divide unit
  // NF plus guard, round and one extra bit for the redundant iteration
  localparam int defaultDivb = 13;

  // half precision with these values, bias is 2**(NE-1)-1 = 15

endpackage

`default_nettype wire

// File: src/divPostPkg.sv
// divPostPkg: control-side types for the divider normalize and round stages
`default_nettype none

package divPostPkg;

  // rounding modes, encoded as in the RISC-V frm field
  // codes 5 to 7 are reserved and never held in the mode register
  typedef enum logic [2:0] {
    // nearest, ties to even
    rmRne = 3'd0,
    // toward zero, plain truncation
    rmRtz = 3'd1,
    // toward minus infinity
    rmRdn = 3'd2,
    // toward plus infinity
    rmRup = 3'd3,
    // nearest, ties away from zero
    rmRmm = 3'd4
  } roundModeE;

endpackage

`default_nettype wire

// File: src/divShiftIf.sv
// divShiftIf: shift decision bundle between the shift calculator and the normalizing shifter
`default_nettype none

interface divShiftIf #(
  parameter int NE,
  parameter int NF,
  parameter int DIVB
);

  // shifter word holds NF leading zeros, the quotient and one tail zero
  localparam int shiftW = NF + DIVB + 2;
  // amount is the non-negative part of an NE+2 bit signed shift
  localparam int shiftAmtW = NE + 1;

  // left-shift amount into the normalizing shifter
  logic [shiftAmtW-1:0] shiftAmt;
  // quotient already placed inside the shifter word
  logic [shiftW-1:0]    shiftIn;
  // exponent zero or negative
  logic                 resSubnorm;
  // subnormal shift is usable, otherwise everything goes to sticky
  logic                 subnormShiftPos;

  modport calc (output shiftAmt, shiftIn, resSubnorm, subnormShiftPos);
  modport norm (input shiftAmt, shiftIn, resSubnorm, subnormShiftPos);

endinterface

`default_nettype wire

// File: src/divShiftCalc.sv
// divShiftCalc picks the normal or subnormal left shift and places the quotient for the shifter
`default_nettype none

module divShiftCalc #(
  parameter int NE,
  parameter int NF,
  parameter int DIVB
) (
  // quotient significand with the integer bit at DIVB
  input  logic [DIVB:0]         qm,
  // signed biased exponent two bits wider than the field
  input  logic signed [NE+1:0]  qe,
  divShiftIf.calc               shift
);

  localparam int shiftAmtW = NE + 1;

  // NF + qe which may go negative for tiny results
  logic signed [NE+1:0] subnormShift;

  // zero or negative exponent means the result lands below the normal range
  // qe of 1 with a leading zero is caught later after the shift
  assign shift.resSubnorm = qe[NE+1] | ~|qe;

  // subnormal case
  //   quotient x.xxxx with exponent qe
  //   shifting left by NF + qe puts it one bit above the subnormal window
  //   the shifter then drops it back by one bit
  assign subnormShift = (NE+2)'(NF) + qe;
  assign shift.subnormShiftPos = ~subnormShift[NE+1];

  // negative amount is clamped to zero so no bit is pushed out the top
  // the shifter then folds the whole word into sticky
  // normal case is always NF and the one-bit fixup for a quotient below one
  // comes afterwards
  always_comb begin
    if (!shift.resSubnorm) begin
      shift.shiftAmt = shiftAmtW'(NF);
    end else if (shift.subnormShiftPos) begin
      shift.shiftAmt = subnormShift[shiftAmtW-1:0];
    end else begin
      shift.shiftAmt = '0;
    end
  end

  // NF zeros in front so a left shift of up to NF loses nothing
  // one zero behind so a later one-bit right shift loses nothing either
  assign shift.shiftIn = {{NF{1'b0}}, qm, 1'b0};

endmodule

`default_nettype wire

// File: src/divNormShift.sv
// divNormShift: normalizing shifter, exponent fixup and stage 1 pipeline register
`default_nettype none

module divNormShift #(
  parameter int NE,
  parameter int NF,
  parameter int DIVB
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   inValid,
  input  logic signed [NE+1:0]   qe,
  input  logic                   sign,
  input  logic                   sticky,
  input  divPostPkg::roundModeE  rm,
  divShiftIf.norm                shift,
  output logic                   s1Valid,
  // {lead, fraction, guard, sticky}
  output logic [NF+2:0]          s1Sig,
  output logic [NE-1:0]          s1Exp,
  output logic                   s1Sign,
  output divPostPkg::roundModeE  s1Rm
);

  localparam int shiftW = NF + DIVB + 2;
  localparam logic signed [NE+1:0] expOne = 1;

  logic [shiftW-1:0] shifted;
  logic [shiftW-1:0] aligned;
  logic              leadZero;
  logic              extraShift;
  logic              allSticky;
  logic              stickyNext;
  logic [NF+2:0]     sigNext;
  logic [NE-1:0]     expNext;

  assign shifted = shift.shiftIn << shift.shiftAmt;

  // quotient below one leaves the top bit clear after the NF shift
  assign leadZero = ~shifted[shiftW-1];
  // one more bit only while the exponent can still drop and stay normal
  assign extraShift = ~shift.resSubnorm & leadZero & (qe > expOne);
  // exponent so low that even the guard bit is below the word
  assign allSticky = shift.resSubnorm & ~shift.subnormShiftPos;

  // line the word up so the window is always lead, NF fraction, guard, rest
  // subnormals sit one bit lower, their lead position is zero
  // the tail zero keeps the right shift exact
  always_comb begin
    if (shift.resSubnorm) begin
      aligned = shifted >> 1;
    end else if (extraShift) begin
      aligned = shifted << 1;
    end else begin
      aligned = shifted;
    end
  end

  // everything below guard collapses into sticky
  always_comb begin
    if (allSticky) begin
      stickyNext = sticky | (|aligned);
      sigNext = {{(NF+2){1'b0}}, stickyNext};
    end else begin
      stickyNext = sticky | (|aligned[shiftW-NF-3:0]);
      sigNext = {aligned[shiftW-1 -: NF+2], stickyNext};
    end
  end

  // exponent field
  //   subnormal              0
  //   below one, qe above 1  qe - 1
  //   below one, qe of 1     0, the value is 0.1xxx times 2**(1-bias)
  //   otherwise              qe
  always_comb begin
    if (shift.resSubnorm) begin
      expNext = '0;
    end else if (extraShift) begin
      expNext = NE'(qe - expOne);
    end else if (leadZero) begin
      expNext = '0;
    end else begin
      expNext = NE'(qe);
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= inValid;
    end
  end

  // mode is taken here, so a write on this same edge applies to later items
  always_ff @(posedge clk) begin
    if (inValid) begin
      s1Sig  <= sigNext;
      s1Exp  <= expNext;
      s1Sign <= sign;
      s1Rm   <= rm;
    end
  end

  // nonzero exponent field needs the hidden one in place
  assert property (@(posedge clk) disable iff (!rstN)
    s1Valid && (s1Exp != '0) |-> s1Sig[NF+2])
    else $error("divNormShift: normal result without leading one");

endmodule

`default_nettype wire

// File: src/roundModeReg.sv
// roundModeReg holds the rounding mode loaded by a config write strobe
`default_nettype none

module roundModeReg (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   cfgWe,
  input  logic [2:0]             cfgRm,
  output divPostPkg::roundModeE  rm
);

  logic legalRm;

  // reserved codes are dropped and the old mode stays
  assign legalRm = cfgRm inside {divPostPkg::rmRne, divPostPkg::rmRtz, divPostPkg::rmRdn,
                                 divPostPkg::rmRup, divPostPkg::rmRmm};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rm <= divPostPkg::rmRne;
    end else if (cfgWe && legalRm) begin
      rm <= divPostPkg::roundModeE'(cfgRm);
    end
  end

endmodule

`default_nettype wire

// File: src/divRound.sv
// divRound rounds the normalized quotient, packs sign, exponent and fraction and registers stage 2
`default_nettype none

module divRound #(
  parameter int NE,
  parameter int NF
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   s1Valid,
  // {lead, fraction, guard, sticky}
  input  logic [NF+2:0]          s1Sig,
  input  logic [NE-1:0]          s1Exp,
  input  logic                   s1Sign,
  input  divPostPkg::roundModeE  s1Rm,
  output logic                   outValid,
  output logic [NE+NF:0]         result,
  output logic                   inexact
);

  logic          lead;
  logic          lsb;
  logic          guard;
  logic          stickyBit;
  logic          anyRem;
  logic          roundUp;
  logic [NF+1:0] mantSum;
  logic          expInc;
  logic [NE-1:0] expOut;

  assign lead      = s1Sig[NF+2];
  assign lsb       = s1Sig[2];
  assign guard     = s1Sig[1];
  assign stickyBit = s1Sig[0];
  // anything at all dropped below the kept fraction
  assign anyRem    = guard | stickyBit;

  // round-up decision per mode
  // nearest even uses lsb only to break an exact tie
  always_comb begin
    case (s1Rm)
      divPostPkg::rmRne: roundUp = guard & (stickyBit | lsb);
      divPostPkg::rmRtz: roundUp = 1'b0;
      divPostPkg::rmRdn: roundUp = s1Sign & anyRem;
      divPostPkg::rmRup: roundUp = ~s1Sign & anyRem;
      divPostPkg::rmRmm: roundUp = guard;
      default:           roundUp = 1'b0;
    endcase
  end

  // add one ulp to lead.fraction with a spare carry bit on top
  assign mantSum = {1'b0, lead, s1Sig[NF+1:2]} + (NF+2)'(roundUp);

  // exponent goes up when
  //   1.11..1 carries into 10.00..0 and the fraction wraps to zero
  //   a subnormal 0.11..1 carries into the smallest normal 1.00..0
  assign expInc = mantSum[NF+1] | (mantSum[NF] & ~lead);
  assign expOut = s1Exp + NE'(expInc);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= s1Valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1Valid) begin
      result  <= {s1Sign, expOut, mantSum[NF-1:0]};
      inexact <= anyRem;
    end
  end

  // overflow to infinity is not handled here so the field stays below all ones
  assert property (@(posedge clk) disable iff (!rstN)
    s1Valid |-> !(&expOut))
    else $error("divRound: exponent %0d reaches the infinity code", expOut);

endmodule

`default_nettype wire

// File: src/divPostTop.sv
// divPostTop: divider back end, shift decision, normalize, mode register and rounder
`default_nettype none

module divPostTop #(
  parameter int NE   = fpFmtPkg::defaultNe,
  parameter int NF   = fpFmtPkg::defaultNf,
  parameter int DIVB = fpFmtPkg::defaultDivb
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   inValid,
  input  logic [DIVB:0]          qm,
  input  logic signed [NE+1:0]   qe,
  input  logic                   sign,
  input  logic                   sticky,
  input  logic                   cfgWe,
  input  logic [2:0]             cfgRm,
  output logic                   outValid,
  output logic [NE+NF:0]         result,
  output logic                   inexact,
  output divPostPkg::roundModeE  curRm
);

  // stage 1 to stage 2
  logic                  s1Valid;
  logic [NF+2:0]         s1Sig;
  logic [NE-1:0]         s1Exp;
  logic                  s1Sign;
  divPostPkg::roundModeE s1Rm;

  divShiftIf #(.NE(NE), .NF(NF), .DIVB(DIVB)) shiftBus ();

  divShiftCalc #(.NE(NE), .NF(NF), .DIVB(DIVB)) shiftCalc0 (
    .qm    (qm),
    .qe    (qe),
    .shift (shiftBus.calc)
  );

  // mode register output also drives the readback port
  roundModeReg modeReg0 (
    .clk   (clk),
    .rstN  (rstN),
    .cfgWe (cfgWe),
    .cfgRm (cfgRm),
    .rm    (curRm)
  );

  divNormShift #(.NE(NE), .NF(NF), .DIVB(DIVB)) normShift0 (
    .clk     (clk),
    .rstN    (rstN),
    .inValid (inValid),
    .qe      (qe),
    .sign    (sign),
    .sticky  (sticky),
    .rm      (curRm),
    .shift   (shiftBus.norm),
    .s1Valid (s1Valid),
    .s1Sig   (s1Sig),
    .s1Exp   (s1Exp),
    .s1Sign  (s1Sign),
    .s1Rm    (s1Rm)
  );

  divRound #(.NE(NE), .NF(NF)) round0 (
    .clk      (clk),
    .rstN     (rstN),
    .s1Valid  (s1Valid),
    .s1Sig    (s1Sig),
    .s1Exp    (s1Exp),
    .s1Sign   (s1Sign),
    .s1Rm     (s1Rm),
    .outValid (outValid),
    .result   (result),
    .inexact  (inexact)
  );

endmodule

`default_nettype wire

// File: verif/divPostTb.sv
// divPostTb: random stimulus and reference model check of the divider normalize and round back end
`default_nettype none

module divPostTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NE = fpFmtPkg::defaultNe;
  localparam int NF = fpFmtPkg::defaultNf;
  localparam int DIVB = fpFmtPkg::defaultDivb;

  logic                  clk;
  logic                  rstN;
  logic                  inValid;
  logic [DIVB:0]         qm;
  logic signed [NE+1:0]  qe;
  logic                  sign;
  logic                  sticky;
  logic                  cfgWe;
  logic [2:0]            cfgRm;
  logic                  outValid;
  logic [NE+NF:0]        result;
  logic                  inexact;
  divPostPkg::roundModeE curRm;

  // scoreboard, {inexact, result} and the cycle each result is due
  logic [NE+NF+1:0]      expQ[$];
  int                    dueQ[$];
  int                    cycleCount = 0;
  logic [31:0]           lcgState = 32'h3668_627b;
  // mode the DUT holds after all writes driven so far
  divPostPkg::roundModeE modelRm;

  divPostTop #(.NE(NE), .NF(NF), .DIVB(DIVB)) dut0 (
    .clk(clk), .rstN(rstN), .inValid(inValid), .qm(qm), .qe(qe), .sign(sign),
    .sticky(sticky), .cfgWe(cfgWe), .cfgRm(cfgRm), .outValid(outValid),
    .result(result), .inexact(inexact), .curRm(curRm)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic int randRange(input int lo, input int hi);
    logic [31:0] r;
    r = nextRand();
    return lo + int'((r >> 8) % (hi - lo + 1));
  endfunction

  function automatic logic randBit();
    logic [31:0] r;
    r = nextRand();
    return r[31];
  endfunction

  // leading one in the integer bit, or in the bit below it
  function automatic logic [DIVB:0] randQm(input logic leadHigh);
    logic [31:0] r;
    logic [DIVB:0] q;
    r = nextRand();
    q = r[31 -: DIVB+1];
    // now and then a quotient with a clean tail, so exact results show up
    if (r[3:2] == 2'b00) begin
      q[3:0] = 4'h0;
    end
    q[DIVB] = leadHigh;
    q[DIVB-1] = leadHigh ? q[DIVB-1] : 1'b1;
    return q;
  endfunction

  // value is q / 2**DIVB * 2**(e - bias), sticky adds a bit below q
  // returns {inexact, sign, exponent, fraction}
  function automatic logic [NE+NF+1:0] modelDiv(input logic [DIVB:0] q, input int e,
      input logic s, input logic st, input divPostPkg::roundModeE mode);
    int cand;
    int eff;
    int n;
    longint kept;
    longint rem;
    longint half;
    longint mag;
    logic inex;
    logic gt;
    logic tie;
    logic up;
    // exponent field of the leading one
    cand = q[DIVB] ? e : e - 1;
    // gradual underflow, subnormals use the scale of field 1
    eff = (cand < 1) ? 1 : cand;
    // right shift from quotient units to result ulps
    n = DIVB - NF - e + eff;
    // beyond this everything is below half an ulp anyway
    if (n > DIVB + 2) begin
      n = DIVB + 2;
    end
    kept = longint'(q) >> n;
    rem = longint'(q) & ((longint'(1) << n) - 1);
    half = longint'(1) << (n - 1);
    inex = (rem != 0) || st;
    gt = (rem > half) || ((rem == half) && st);
    tie = (rem == half) && !st;
    case (mode)
      divPostPkg::rmRne: up = gt || (tie && kept[0]);
      divPostPkg::rmRtz: up = 1'b0;
      divPostPkg::rmRdn: up = s && inex;
      divPostPkg::rmRup: up = !s && inex;
      default:           up = gt || tie;
    endcase
    // a carry out of the fraction lands in the exponent field by itself
    mag = (longint'(eff - 1) << NF) + kept + longint'(up);
    return {inex, s, mag[NE+NF-1:0]};
  endfunction

  task automatic abortRun(input string line);
    $display("%s", line);
    $display("Test failures found");
    $fatal(1, "simulation stopped at first error");
  endtask

  // compare everything the DUT shows at the falling edge
  task automatic checkOutputs();
    logic [NE+NF+1:0] exp;
    int due;
    assert (curRm == modelRm)
      else abortRun($sformatf("FAILED at %0t: curRm %0d, expected %0d", $time, curRm, modelRm));
    if (outValid) begin
      assert (expQ.size() > 0)
        else abortRun($sformatf("FAILED at %0t: outValid with no item in flight", $time));
      exp = expQ.pop_front();
      due = dueQ.pop_front();
      assert (cycleCount == due)
        else abortRun($sformatf("FAILED at %0t: result in cycle %0d, due in %0d",
                                $time, cycleCount, due));
      assert (result == exp[NE+NF:0])
        else abortRun($sformatf("FAILED at %0t: result %h, expected %h",
                                $time, result, exp[NE+NF:0]));
      assert (inexact == exp[NE+NF+1])
        else abortRun($sformatf("FAILED at %0t: inexact %b, expected %b",
                                $time, inexact, exp[NE+NF+1]));
    end else if (dueQ.size() > 0) begin
      assert (dueQ[0] > cycleCount)
        else abortRun($sformatf("FAILED at %0t: result due in cycle %0d missing",
                                $time, dueQ[0]));
    end
  endtask

  // one clock: check, then drive on the falling edge
  task automatic stepCycle(input logic valid, input logic [DIVB:0] q, input int e,
      input logic s, input logic st, input logic we, input logic [2:0] code);
    @(negedge clk);
    checkOutputs();
    inValid = valid;
    qm = q;
    qe = e[NE+1:0];
    sign = s;
    sticky = st;
    cfgWe = we;
    cfgRm = code;
    // item sampled on this edge still sees the old mode
    if (valid) begin
      expQ.push_back(modelDiv(q, e, s, st, modelRm));
      dueQ.push_back(cycleCount + 2);
    end
    if (we && code <= 3'd4) begin
      modelRm = divPostPkg::roundModeE'(code);
    end
  endtask

  task automatic idleCycle();
    stepCycle(1'b0, randQm(randBit()), randRange(-20, 29), randBit(), randBit(), 1'b0, 3'd0);
  endtask

  // kind 0 normal, 1 below one, 2 subnormal, other a mix of all
  task automatic randomItem(input int kind, input logic we, input logic [2:0] code);
    logic [DIVB:0] q;
    int e;
    case (kind)
      0: begin
        q = randQm(1'b1);
        e = randRange(2, 28);
      end
      1: begin
        q = randQm(1'b0);
        e = randBit() ? randRange(1, 2) : randRange(3, 29);
      end
      2: begin
        q = randQm(randBit());
        // deep negative values push the whole quotient into sticky
        e = randBit() ? randRange(-12, 0) : randRange(-60, -11);
      end
      default: begin
        q = randQm(randBit());
        e = randRange(-14, 29);
      end
    endcase
    stepCycle(1'b1, q, e, randBit(), randBit(), we, code);
  endtask

  initial begin
    int i;
    int m;
    int drainCount;
    rstN = 1'b0;
    inValid = 1'b0;
    qm = '0;
    qe = '0;
    sign = 1'b0;
    sticky = 1'b0;
    cfgWe = 1'b0;
    cfgRm = 3'd0;
    modelRm = divPostPkg::rmRne;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    // quiet after reset, outValid low and mode nearest even
    for (i = 0; i < 4; i++) begin
      idleCycle();
    end
    // normal, below one and subnormal items with random gaps
    for (m = 0; m < 3; m++) begin
      for (i = 0; i < 40; i++) begin
        randomItem(m, 1'b0, 3'd0);
        if (randBit()) begin
          idleCycle();
        end
      end
    end
    // carries into the next binade, subnormal to smallest normal, ties, exact
    stepCycle(1'b1, 14'h1fff, 1, 1'b0, 1'b0, 1'b0, 3'd0);
    stepCycle(1'b1, 14'h3fff, 0, 1'b1, 1'b0, 1'b0, 3'd0);
    stepCycle(1'b1, 14'h3fff, 10, 1'b0, 1'b0, 1'b0, 3'd0);
    stepCycle(1'b1, 14'h2004, 5, 1'b0, 1'b0, 1'b0, 3'd0);
    stepCycle(1'b1, 14'h200c, 5, 1'b1, 1'b0, 1'b0, 3'd0);
    stepCycle(1'b1, 14'h2000, -3, 1'b0, 1'b0, 1'b0, 3'd0);
    // each legal mode written together with an item, then an illegal code
    for (m = 0; m < 5; m++) begin
      randomItem(3, 1'b1, 3'(m));
      for (i = 0; i < 8; i++) begin
        randomItem(3, 1'b0, 3'd0);
      end
      randomItem(3, 1'b1, 3'(5 + m % 3));
      for (i = 0; i < 4; i++) begin
        randomItem(3, 1'b0, 3'd0);
      end
    end
    // back to back stream with occasional mode writes
    for (i = 0; i < 60; i++) begin
      randomItem(3, (randRange(0, 7) == 0), 3'(randRange(0, 7)));
    end
    drainCount = 0;
    while (expQ.size() > 0 && drainCount < 16) begin
      idleCycle();
      drainCount++;
    end
    if (expQ.size() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      abortRun("timeout: results still missing after the input stream ended");
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
src/fpFmtPkg.sv
src/divPostPkg.sv
src/divShiftIf.sv
src/divShiftCalc.sv
src/divNormShift.sv
src/roundModeReg.sv
src/divRound.sv
src/divPostTop.sv
verif/divPostTb.sv

// File: Makefile
# Verilator build and run of the divider back end testbench

VERILATOR ?= verilator
TOP       ?= divPostTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
